// File: rtl/corr_cfg.svh
/*
 * Build-time sizes and packet constants of the correlator.
 * Channel masks arrive in a 4-bit command argument, so at most 4 channels.
 * The packet carries every count as two bytes, so counters are 16 bits wide.
 * The window length is 2**(len_exp + CORR_LEN_BASE) cycles.
 */
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

`default_nettype none

`define CORR_NUM_INPUTS 4
`define CORR_MAX_LAG 4
`define CORR_RESOLUTION 16

`define CORR_HEADER 8'hA5
`define CORR_LEN_BASE 4

`default_nettype wire

`endif

// File: rtl/corr_pkg.sv
/*
 * Shared types of the correlator.
 * The opcode lives in the upper nibble of a command byte.
 * PKT_BYTES counts header, sequence, config, overflow, counts and checksum.
 */
`include "corr_cfg.svh"

`default_nettype none

package corr_pkg;

	typedef enum logic [3:0] {
		OP_NOP        = 4'h0,
		OP_SET_LEN    = 4'h1,
		OP_SET_INVERT = 4'h2,
		OP_SET_ENABLE = 4'h3,
		OP_START      = 4'h4,
		OP_ABORT      = 4'h5
	} cmd_op_e;

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_INTEGRATE,
		PS_WAIT_TX
	} parser_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SEND,
		TX_CHECKSUM
	} tx_state_e;

	typedef struct packed {
		logic [`CORR_NUM_INPUTS-1:0] invert_mask;
		logic [`CORR_NUM_INPUTS-1:0] enable_mask;
		logic [3:0]                  len_exp;
	} chan_cfg_t;

	// lag[0] holds lag 1
	typedef struct packed {
		logic [`CORR_RESOLUTION-1:0]                   pulse;
		logic [`CORR_MAX_LAG-1:0][`CORR_RESOLUTION-1:0] lag;
		logic                                          overflow;
	} chan_counts_t;

	localparam int NUM_WORDS = `CORR_NUM_INPUTS * (`CORR_MAX_LAG + 1);
	localparam int PKT_BYTES = 4 + 2 * NUM_WORDS + 1;

endpackage

`default_nettype wire

// File: rtl/cmd_parser.sv
/*
 * Command decoder and integration window timer.
 * Config ops act only while idle; during a window only OP_ABORT is taken.
 * Once a window ends, commands are held off until the packet is handed off.
 */
`include "corr_cfg.svh"

`default_nettype none

module cmd_parser import corr_pkg::*; (
	input  logic       intclk,
	input  logic       rst_n,
	input  logic       cmd_valid,
	input  logic [7:0] cmd_data,
	output logic       cmd_ready,
	output chan_cfg_t  cfg,
	output logic       clear,
	output logic       window,
	output logic       window_done,
	input  logic       snap_taken
);

	// Longest window is 2**(15 + CORR_LEN_BASE) cycles
	localparam int WIN_W = 16 + `CORR_LEN_BASE;

	parser_state_e    state;
	cmd_op_e          op;
	logic [3:0]       arg;
	logic             accept;
	logic [WIN_W-1:0] remain;
	logic [WIN_W-1:0] win_last;
	logic             done_pend;

	assign op        = cmd_op_e'(cmd_data[7:4]);
	assign arg       = cmd_data[3:0];
	assign cmd_ready = (state == PS_IDLE) || (state == PS_INTEGRATE);
	assign accept    = cmd_valid && cmd_ready;
	assign win_last  = (WIN_W'(1) << (cfg.len_exp + `CORR_LEN_BASE)) - WIN_W'(1);

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= PS_IDLE;
			cfg         <= '{invert_mask: '0, enable_mask: '1, len_exp: '0};
			clear       <= 1'b0;
			window      <= 1'b0;
			window_done <= 1'b0;
			done_pend   <= 1'b0;
			remain      <= '0;
		end else begin
			clear       <= 1'b0;
			done_pend   <= 1'b0;
			window_done <= done_pend;
			case (state)
				PS_IDLE: begin
					if (accept) begin
						case (op)
							OP_SET_LEN:    cfg.len_exp <= arg;
							OP_SET_INVERT: cfg.invert_mask <= arg[`CORR_NUM_INPUTS-1:0];
							OP_SET_ENABLE: cfg.enable_mask <= arg[`CORR_NUM_INPUTS-1:0];
							OP_START: begin
								clear <= 1'b1;
								state <= PS_INTEGRATE;
							end
							default: ;
						endcase
					end
				end
				PS_INTEGRATE: begin
					if (accept && op == OP_ABORT) begin
						window <= 1'b0;
						state  <= PS_IDLE;
					end else if (clear) begin
						// Counters are cleared now, open the window
						window <= 1'b1;
						remain <= win_last;
					end else if (remain == '0) begin
						window    <= 1'b0;
						done_pend <= 1'b1;
						state     <= PS_WAIT_TX;
					end else begin
						remain <= remain - WIN_W'(1);
					end
				end
				PS_WAIT_TX: begin
					if (snap_taken)
						state <= PS_IDLE;
				end
				default: state <= PS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/delay_line.sv
/*
 * History of past conditioned samples of one channel.
 * history[k] holds the sample from k+1 cycles ago; it runs without pause.
 */
`include "corr_cfg.svh"

`default_nettype none

module delay_line (
	input  logic                     intclk,
	input  logic                     rst_n,
	input  logic                     sample,
	output logic [`CORR_MAX_LAG-1:0] history
);

	localparam int DEPTH = `CORR_MAX_LAG;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			history <= '0;
		end else begin
			history <= (history << 1) | DEPTH'(sample);
		end
	end

endmodule

`default_nettype wire

// File: rtl/pulse_counter.sv
/*
 * Saturating event counter.
 * Sticks at all ones; the first increment past that sets overflow.
 * clear takes priority over count_en.
 */
`include "corr_cfg.svh"

`default_nettype none

module pulse_counter (
	input  logic                        intclk,
	input  logic                        rst_n,
	input  logic                        clear,
	input  logic                        count_en,
	output logic [`CORR_RESOLUTION-1:0] count,
	output logic                        overflow
);

	logic at_max;

	assign at_max = &count;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			count    <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			count    <= '0;
			overflow <= 1'b0;
		end else if (count_en) begin
			if (at_max)
				overflow <= 1'b1;
			else
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/channel_correlator.sv
/*
 * One input channel: register, invert/mask, delay line and counters.
 * The line and the window are registered together, so a sample is counted
 * when the window was open at the edge that captured it.
 */
`include "corr_cfg.svh"

`default_nettype none

module channel_correlator import corr_pkg::*; #(
	parameter int channel_index = 0
) (
	input  logic         intclk,
	input  logic         rst_n,
	input  logic         line,
	input  chan_cfg_t    cfg,
	input  logic         clear,
	input  logic         window,
	output chan_counts_t counts
);

	logic                                          line_q;
	logic                                          window_q;
	logic                                          sample;
	logic [`CORR_MAX_LAG-1:0]                      history;
	logic [`CORR_RESOLUTION-1:0]                   pulse_count;
	logic [`CORR_MAX_LAG-1:0][`CORR_RESOLUTION-1:0] lag_count;
	logic [`CORR_MAX_LAG:0]                        ovf;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			line_q   <= 1'b0;
			window_q <= 1'b0;
		end else begin
			line_q   <= line;
			window_q <= window;
		end
	end

	assign sample = (line_q ^ cfg.invert_mask[channel_index]) & cfg.enable_mask[channel_index];

	delay_line u_delay (
		.intclk  (intclk),
		.rst_n   (rst_n),
		.sample  (sample),
		.history (history)
	);

	pulse_counter u_pulse (
		.intclk   (intclk),
		.rst_n    (rst_n),
		.clear    (clear),
		.count_en (sample & window_q),
		.count    (pulse_count),
		.overflow (ovf[0])
	);

	// Lag k+1 pairs the current sample with history tap k
	for (genvar k = 0; k < `CORR_MAX_LAG; k++) begin : g_lag
		pulse_counter u_lag (
			.intclk   (intclk),
			.rst_n    (rst_n),
			.clear    (clear),
			.count_en (sample & history[k] & window_q),
			.count    (lag_count[k]),
			.overflow (ovf[k+1])
		);
	end

	assign counts.pulse    = pulse_count;
	assign counts.lag      = lag_count;
	assign counts.overflow = |ovf;

endmodule

`default_nettype wire

// File: rtl/packet_builder.sv
/*
 * Snapshots all channel counts when a window closes and streams them out.
 * Byte order: header, sequence, config, overflow mask, counts (MSB first,
 * pulse then lags per channel), XOR checksum of all earlier bytes.
 * snap_taken pulses when the checksum byte is accepted.
 */
`include "corr_cfg.svh"

`default_nettype none

module packet_builder import corr_pkg::*; (
	input  logic                                intclk,
	input  logic                                rst_n,
	input  logic                                window_done,
	input  chan_counts_t [`CORR_NUM_INPUTS-1:0] counts,
	output logic                                snap_taken,
	output logic                                pkt_valid,
	output logic [7:0]                          pkt_data,
	input  logic                                pkt_ready
);

	localparam logic [7:0] LAST_DATA = 8'(PKT_BYTES - 2);
	localparam logic [7:0] CFG_BYTE  = {4'(`CORR_NUM_INPUTS - 1), 4'(`CORR_MAX_LAG - 1)};

	tx_state_e                                   state;
	logic [7:0]                                  byte_idx;
	logic [7:0]                                  seq_num;
	logic [7:0]                                  csum;
	logic [7:0]                                  data_byte;
	logic [6:0]                                  word_sel;
	logic [`CORR_NUM_INPUTS-1:0]                 ovf_mask;
	chan_counts_t [`CORR_NUM_INPUTS-1:0]         snap;
	logic [NUM_WORDS-1:0][`CORR_RESOLUTION-1:0] words;

	always_ff @(posedge intclk) begin
		if (state == TX_IDLE && window_done)
			snap <= counts;
	end

	// Flatten the snapshot into packet word order
	always_comb begin
		for (int ch = 0; ch < `CORR_NUM_INPUTS; ch++) begin
			words[ch * (`CORR_MAX_LAG + 1)] = snap[ch].pulse;
			for (int k = 0; k < `CORR_MAX_LAG; k++)
				words[ch * (`CORR_MAX_LAG + 1) + k + 1] = snap[ch].lag[k];
			ovf_mask[ch] = snap[ch].overflow;
		end
	end

	// Count bytes start at index 4, two per word
	assign word_sel = byte_idx[7:1] - 7'd2;

	always_comb begin
		case (byte_idx)
			8'd0:    data_byte = `CORR_HEADER;
			8'd1:    data_byte = seq_num;
			8'd2:    data_byte = CFG_BYTE;
			8'd3:    data_byte = 8'(ovf_mask);
			default: data_byte = byte_idx[0] ? words[word_sel][7:0] : words[word_sel][15:8];
		endcase
	end

	assign pkt_valid  = (state != TX_IDLE);
	assign pkt_data   = (state == TX_CHECKSUM) ? csum : data_byte;
	assign snap_taken = (state == TX_CHECKSUM) && pkt_ready;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			byte_idx <= '0;
			seq_num  <= '0;
			csum     <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (window_done) begin
						state    <= TX_SEND;
						byte_idx <= '0;
						csum     <= '0;
					end
				end
				TX_SEND: begin
					if (pkt_ready) begin
						csum     <= csum ^ data_byte;
						byte_idx <= byte_idx + 8'd1;
						if (byte_idx == LAST_DATA)
							state <= TX_CHECKSUM;
					end
				end
				TX_CHECKSUM: begin
					if (pkt_ready) begin
						state   <= TX_IDLE;
						seq_num <= seq_num + 8'd1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/correlator_top.sv
/*
 * Pulse correlator top level.
 * Command bytes in, one packet out per completed window.
 * busy is high exactly while samples are being counted.
 */
`include "corr_cfg.svh"

`default_nettype none

module correlator_top import corr_pkg::*; (
	input  logic                        intclk,
	input  logic                        rst_n,
	input  logic [`CORR_NUM_INPUTS-1:0] line_in,
	input  logic                        cmd_valid,
	input  logic [7:0]                  cmd_data,
	output logic                        cmd_ready,
	output logic                        busy,
	output logic                        pkt_valid,
	output logic [7:0]                  pkt_data,
	input  logic                        pkt_ready
);

	chan_cfg_t                           cfg;
	logic                                clear;
	logic                                window;
	logic                                window_done;
	logic                                snap_taken;
	chan_counts_t [`CORR_NUM_INPUTS-1:0] counts;

	cmd_parser u_parser (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_data    (cmd_data),
		.cmd_ready   (cmd_ready),
		.cfg         (cfg),
		.clear       (clear),
		.window      (window),
		.window_done (window_done),
		.snap_taken  (snap_taken)
	);

	for (genvar i = 0; i < `CORR_NUM_INPUTS; i++) begin : g_chan
		channel_correlator #(.channel_index(i)) u_chan (
			.intclk (intclk),
			.rst_n  (rst_n),
			.line   (line_in[i]),
			.cfg    (cfg),
			.clear  (clear),
			.window (window),
			.counts (counts[i])
		);
	end

	packet_builder u_builder (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.window_done (window_done),
		.counts      (counts),
		.snap_taken  (snap_taken),
		.pkt_valid   (pkt_valid),
		.pkt_data    (pkt_data),
		.pkt_ready   (pkt_ready)
	);

	assign busy = window;

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
/*
 * 40 ns clock, reset held low for the first 2 rising edges.
 */
`default_nettype none

module clock_gen (
	output logic intclk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		intclk = 1'b0;
		rst_n  = 1'b0;
		repeat (2) @(posedge intclk);
		rst_n <= 1'b1;
	end

	always #20 intclk = ~intclk;

endmodule

`default_nettype wire

// File: testbench/correlator_properties.sv
/*
 * Handshake and window checks, bound into correlator_top.
 * window_done is taken from inside the top level.
 */
`default_nettype none

module correlator_properties (
	input wire       intclk,
	input wire       rst_n,
	input wire       busy,
	input wire       cmd_ready,
	input wire       window_done,
	input wire       pkt_valid,
	input wire [7:0] pkt_data,
	input wire       pkt_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// Held byte must not change
	a_pkt_stable: assert property (@(posedge intclk) disable iff (!rst_n)
		pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt_data))
		else $error("pkt_data changed while stalled");

	a_no_busy_in_pkt: assert property (@(posedge intclk) disable iff (!rst_n)
		pkt_valid |-> !$rose(busy))
		else $error("busy rose during a packet");

	// Commands held off from window end until packet end
	a_cmd_held: assert property (@(posedge intclk) disable iff (!rst_n)
		window_done || pkt_valid |-> !cmd_ready)
		else $error("cmd_ready high between window end and packet end");

endmodule

bind correlator_top correlator_properties u_props (
	.intclk      (intclk),
	.rst_n       (rst_n),
	.busy        (busy),
	.cmd_ready   (cmd_ready),
	.window_done (window_done),
	.pkt_valid   (pkt_valid),
	.pkt_data    (pkt_data),
	.pkt_ready   (pkt_ready)
);

`default_nettype wire

// File: testbench/correlator_tb.sv
/*
 * Correlator testbench: command stimulus, sample record, reference packet model.
 * The model conditions each sample with the config in force after its edge.
 * The window is timed from the START edge and the length exponent.
 * Run length is bounded by a cycle counter.
 */
`include "corr_cfg.svh"

`default_nettype none

module correlator_tb import corr_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WIN_SUM = 16 + 16 + 64 + 32 + 128 + 16 + 65536;
	localparam int LIMIT   = WIN_SUM + 64 * PKT_BYTES * 7 + 4000;

	logic                        intclk;
	logic                        rst_n;
	logic [`CORR_NUM_INPUTS-1:0] line_in;
	logic                        cmd_valid;
	logic [7:0]                  cmd_data;
	logic                        cmd_ready;
	logic                        busy;
	logic                        pkt_valid;
	logic [7:0]                  pkt_data;
	logic                        pkt_ready;

	int         seed = 32'h03e1_0cd5;
	int         cyc;
	int         errors;
	int         pkts_rx;
	int         win_first;
	int         win_last;
	int         line_mode;
	int         ready_mode;
	string      cur_test;
	logic [7:0] exp_seq;
	chan_cfg_t  m_cfg;
	logic [`CORR_NUM_INPUTS-1:0] all_cond[$];
	logic [7:0]                  rx[$];
	logic [7:0]                  last_pkt[PKT_BYTES];
	logic [7:0]                  exp_pkt[PKT_BYTES];

	clock_gen u_clk (.intclk(intclk), .rst_n(rst_n));

	correlator_top UUT (
		.intclk    (intclk),
		.rst_n     (rst_n),
		.line_in   (line_in),
		.cmd_valid (cmd_valid),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.busy      (busy),
		.pkt_valid (pkt_valid),
		.pkt_data  (pkt_data),
		.pkt_ready (pkt_ready)
	);

	// Expected packet from the recorded conditioned samples of one window
	function automatic void build_expected(input int first, input int last,
			input logic [7:0] seq);
		logic [15:0] cnt[`CORR_NUM_INPUTS][`CORR_MAX_LAG+1];
		logic [`CORR_NUM_INPUTS-1:0] ovf;
		logic [7:0] x;
		int w;
		ovf = '0;
		for (int ch = 0; ch < `CORR_NUM_INPUTS; ch++)
			for (int k = 0; k <= `CORR_MAX_LAG; k++)
				cnt[ch][k] = '0;
		for (int i = first; i <= last; i++) begin
			for (int ch = 0; ch < `CORR_NUM_INPUTS; ch++) begin
				for (int k = 0; k <= `CORR_MAX_LAG; k++) begin
					if (all_cond[i][ch] && (k == 0 || (i >= k && all_cond[i-k][ch]))) begin
						if (cnt[ch][k] == 16'hFFFF)
							ovf[ch] = 1'b1;
						else
							cnt[ch][k] = cnt[ch][k] + 16'd1;
					end
				end
			end
		end
		exp_pkt[0] = `CORR_HEADER;
		exp_pkt[1] = seq;
		exp_pkt[2] = {4'(`CORR_NUM_INPUTS - 1), 4'(`CORR_MAX_LAG - 1)};
		exp_pkt[3] = 8'(ovf);
		w = 4;
		for (int ch = 0; ch < `CORR_NUM_INPUTS; ch++) begin
			for (int k = 0; k <= `CORR_MAX_LAG; k++) begin
				exp_pkt[w]   = cnt[ch][k][15:8];
				exp_pkt[w+1] = cnt[ch][k][7:0];
				w = w + 2;
			end
		end
		x = '0;
		for (int b = 0; b < PKT_BYTES - 1; b++)
			x = x ^ exp_pkt[b];
		exp_pkt[PKT_BYTES-1] = x;
	endfunction

	task automatic compare_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %02h, actual %02h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_count(input string what, input logic [`CORR_RESOLUTION-1:0] exp,
			input logic [`CORR_RESOLUTION-1:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_ovf(input logic [`CORR_NUM_INPUTS-1:0] exp,
			input logic [`CORR_NUM_INPUTS-1:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s overflow mask: expected %b, actual %b", cur_test, exp, act);
		end
	endtask

	task automatic compare_busy(input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s busy: expected %b, actual %b", cur_test, exp, act);
		end
	endtask

	function automatic logic [15:0] word_at(input int idx);
		return {last_pkt[4 + 2*idx], last_pkt[5 + 2*idx]};
	endfunction

	// Record samples and config exactly as the DUT sees them at each edge
	always @(posedge intclk) begin : record
		cmd_op_e op;
		int      idx;
		if (rst_n) begin
			op  = cmd_op_e'(cmd_data[7:4]);
			idx = all_cond.size();
			// busy seen at this edge is its value just before the edge
			compare_busy((idx >= win_first) && (idx <= win_last), busy);
			if (cmd_valid && cmd_ready) begin
				case (op)
					OP_SET_LEN:    m_cfg.len_exp = cmd_data[3:0];
					OP_SET_INVERT: m_cfg.invert_mask = cmd_data[3:0];
					OP_SET_ENABLE: m_cfg.enable_mask = cmd_data[3:0];
					OP_START: begin
						win_first = idx + 2;
						win_last  = idx + 1 + (1 << (m_cfg.len_exp + `CORR_LEN_BASE));
					end
					OP_ABORT: begin
						if (idx < win_last)
							win_last = idx;
					end
					default: ;
				endcase
			end
			all_cond.push_back((line_in ^ m_cfg.invert_mask) & m_cfg.enable_mask);
		end
	end

	// Collect packet bytes and compare each finished packet
	always @(posedge intclk) begin : collect
		if (rst_n && pkt_valid && pkt_ready) begin
			rx.push_back(pkt_data);
			if (rx.size() == PKT_BYTES) begin
				build_expected(win_first, win_last, exp_seq);
				for (int b = 0; b < PKT_BYTES; b++)
					last_pkt[b] = rx[b];
				compare_byte("header", exp_pkt[0], rx[0]);
				compare_byte("sequence", exp_pkt[1], rx[1]);
				compare_byte("config", exp_pkt[2], rx[2]);
				compare_ovf(exp_pkt[3][3:0], rx[3][3:0]);
				for (int i = 0; i < NUM_WORDS; i++)
					compare_count($sformatf("ch%0d word%0d", i / 5, i % 5),
						{exp_pkt[4+2*i], exp_pkt[5+2*i]}, {rx[4+2*i], rx[5+2*i]});
				compare_byte("checksum", exp_pkt[PKT_BYTES-1], rx[PKT_BYTES-1]);
				exp_seq = exp_seq + 8'd1;
				pkts_rx++;
				rx.delete();
			end
		end
	end

	always @(posedge intclk) begin : drive_inputs
		logic [31:0] r;
		logic [3:0]  v;
		if (rst_n) begin
			r = $random(seed);
			v = r[3:0];
			if (line_mode == 1)
				v[0] = (cyc % 3 == 0);
			if (line_mode == 2)
				v[3] = 1'b1;
			line_in   <= v;
			pkt_ready <= (ready_mode == 1) ? r[4] : 1'b1;
		end
	end

	always @(posedge intclk) begin : watchdog
		cyc <= cyc + 1;
		if (cyc > LIMIT) begin
			$display("Run stopped after %0d cycles, DUT stopped responding", LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic send_cmd(input cmd_op_e op, input logic [3:0] arg);
		@(posedge intclk);
		cmd_valid <= 1'b1;
		cmd_data  <= {op, arg};
		do @(posedge intclk); while (!cmd_ready);
		cmd_valid <= 1'b0;
	endtask

	task automatic run_test(input string name, input logic [3:0] len, input logic [3:0] inv,
			input logic [3:0] en, input int lmode, input int rmode, input bit abort);
		int base;
		int waited;
		cur_test   = name;
		line_mode  = lmode;
		ready_mode = rmode;
		send_cmd(OP_SET_LEN, len);
		send_cmd(OP_SET_INVERT, inv);
		send_cmd(OP_SET_ENABLE, en);
		repeat (3) @(posedge intclk);
		base = pkts_rx;
		send_cmd(OP_START, 4'h0);
		if (abort) begin
			repeat (5) @(posedge intclk);
			send_cmd(OP_ABORT, 4'h0);
			repeat ((1 << (len + 4)) + 100) @(posedge intclk);
			if (pkts_rx != base) begin
				errors++;
				$display("%s: a packet was sent after the window was aborted", name);
			end
			return;
		end
		if (rmode == 1) begin
			// Command sent during the packet must wait for its end
			while (!pkt_valid) @(posedge intclk);
			send_cmd(OP_NOP, 4'h0);
			if (pkts_rx != base + 1) begin
				errors++;
				$display("%s: command accepted before the packet ended", name);
			end
		end
		waited = 0;
		while (pkts_rx == base && waited < (1 << (len + 4)) + 64 * PKT_BYTES) begin
			@(posedge intclk);
			waited++;
		end
		if (pkts_rx == base) begin
			errors++;
			$display("%s: packet missing or late", name);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("%s: %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
	endtask

	initial begin : main
		int err0;
		line_in    = '0;
		cmd_valid  = 1'b0;
		cmd_data   = '0;
		pkt_ready  = 1'b1;
		m_cfg      = '{invert_mask: '0, enable_mask: '1, len_exp: '0};
		exp_seq    = '0;
		line_mode  = 0;
		ready_mode = 0;
		win_first  = 1;
		win_last   = 0;
		wait (rst_n);
		repeat (2) @(posedge intclk);

		err0 = errors;
		run_test("basic", 4'd0, 4'h0, 4'hF, 0, 0, 1'b0);
		report_test("basic", err0);

		err0 = errors;
		run_test("masks", 4'd0, 4'b0010, 4'b1011, 0, 0, 1'b0);
		compare_count("ch2 pulse", 16'd0, word_at(10));
		report_test("masks", err0);

		// Period 3 on channel 0 makes lag 3 follow every counted pulse
		err0 = errors;
		run_test("lag", 4'd2, 4'h0, 4'hF, 1, 0, 1'b0);
		compare_count("ch0 lag3 vs pulse", {exp_pkt[4], exp_pkt[5]}, word_at(3));
		report_test("lag", err0);

		err0 = errors;
		run_test("backpressure", 4'd1, 4'h0, 4'hF, 0, 1, 1'b0);
		report_test("backpressure", err0);

		err0 = errors;
		run_test("abort", 4'd3, 4'h0, 4'hF, 0, 0, 1'b1);
		run_test("abort_next", 4'd0, 4'h0, 4'hF, 0, 0, 1'b0);
		report_test("abort", err0);

		err0 = errors;
		run_test("saturation", 4'd12, 4'h0, 4'hF, 2, 0, 1'b0);
		compare_count("ch3 pulse", 16'hFFFF, word_at(15));
		compare_count("ch3 lag4", 16'hFFFF, word_at(19));
		compare_ovf(4'b1000, last_pkt[3][3:0] & 4'b1000);
		report_test("saturation", err0);

		$display("Packets received %0d, errors %0d", pkts_rx, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: correlator_top.f
+incdir+rtl
rtl/corr_pkg.sv
rtl/cmd_parser.sv
rtl/delay_line.sv
rtl/pulse_counter.sv
rtl/channel_correlator.sv
rtl/packet_builder.sv
rtl/correlator_top.sv
testbench/clock_gen.sv
testbench/correlator_properties.sv
testbench/correlator_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f correlator_top.f \
		--top-module correlator_tb -Mdir obj_dir -o Vcorrelator_tb

run: build
	./obj_dir/Vcorrelator_tb | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing --assert -f correlator_top.f \
		--top-module correlator_tb
	verilator --lint-only -f correlator_top.f --top-module correlator_top

clean:
	rm -rf obj_dir $(LOG)
